// File: csa_accel.f
+incdir+hw
hw/csa_pkg.sv
hw/csa_regs.sv
hw/csa_in_packer.sv
hw/csa_calc.sv
hw/csa_engine.sv
hw/csa_out_fifo.sv
hw/csa_accel.sv
sim/csa_accel_sva.sv
sim/csa_accel_tb.sv

// File: hw/csa_accel.sv
`default_nettype none
`timescale 1ns/1ps

module csa_accel
(
	input wire aclk,
	input wire reset,
	input wire reg_wen,
	input wire reg_ren,
	input wire csa_pkg::reg_addr_t reg_addr,
	input wire csa_pkg::word_t reg_wdata,
	output csa_pkg::word_t reg_rdata,
	input wire s_tvalid,
	output logic s_tready,
	input wire csa_pkg::word_t s_tdata,
	input wire s_tlast,
	output logic m_tvalid,
	input wire m_tready,
	output csa_pkg::word_t m_tdata,
	output logic m_tlast
);

	csa_pkg::blk_beat_t in_beat;
	csa_pkg::blk_beat_t out_beat;
	csa_pkg::key_t key;
	logic enable;
	logic in_valid;
	logic in_ready;
	logic out_push;
	logic out_credit;
	logic block_done;

	csa_regs u_regs
	(
		.aclk(aclk),
		.reset(reset),
		.reg_wen(reg_wen),
		.reg_ren(reg_ren),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.block_done(block_done),
		.key(key),
		.enable(enable)
	);

	csa_in_packer u_in_packer
	(
		.aclk(aclk),
		.reset(reset),
		.s_tvalid(s_tvalid),
		.s_tready(s_tready),
		.s_tdata(s_tdata),
		.s_tlast(s_tlast),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready)
	);

	csa_engine u_engine
	(
		.aclk(aclk),
		.reset(reset),
		.in_beat(in_beat),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.key(key),
		.enable(enable),
		.out_beat(out_beat),
		.out_push(out_push),
		.out_credit(out_credit)
	);

	csa_out_fifo u_out_fifo
	(
		.aclk(aclk),
		.reset(reset),
		.out_beat(out_beat),
		.out_push(out_push),
		.out_credit(out_credit),
		.block_done(block_done),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready),
		.m_tdata(m_tdata),
		.m_tlast(m_tlast)
	);

endmodule

`default_nettype wire

// File: hw/csa_calc.sv
`default_nettype none
`timescale 1ns/1ps
`include "csa_defines.svh"

module csa_calc
(
	input wire aclk,
	input wire reset,
	input wire start,
	input wire csa_pkg::blk_beat_t start_beat,
	input wire csa_pkg::key_t start_key,
	input wire start_enable,
	output logic done,
	output csa_pkg::blk_beat_t done_beat
);

	csa_pkg::calc_state_t state;
	logic [3:0] rnd;
	csa_pkg::word_t l;
	csa_pkg::word_t r;
	csa_pkg::word_t rk;
	csa_pkg::word_t mixed;
	csa_pkg::word_t f;
	csa_pkg::key_t key_q;
	logic enable_q;
	logic last_q;

	assign rk = rnd[0] ? key_q[63:32] : key_q[31:0]; // odd rounds take the high key word.
	assign mixed = r ^ rk;
	assign f = {mixed[26:0], mixed[31:27]} + rk;
	assign done_beat = '{data: {r, l}, last: last_q};

	// done rises CSA_ROUNDS+1 cycles after start, bypass included.
	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			state <= csa_pkg::CALC_IDLE;
			rnd <= 4'd0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				csa_pkg::CALC_IDLE:
					if (start)
					begin
						state <= csa_pkg::CALC_RUN;
						rnd <= 4'd0;
					end
				default:
					if (rnd == `CSA_ROUNDS - 1)
					begin
						state <= csa_pkg::CALC_IDLE;
						done <= 1'b1;
					end
					else
						rnd <= rnd + 4'd1;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (state == csa_pkg::CALC_IDLE && start)
		begin
			l <= start_beat.data[31:0];
			r <= start_beat.data[63:32];
			key_q <= start_key;
			enable_q <= start_enable;
			last_q <= start_beat.last;
		end
		else if (state == csa_pkg::CALC_RUN && enable_q)
		begin
			l <= r;
			r <= l ^ f;
		end
	end

endmodule

`default_nettype wire

// File: hw/csa_defines.svh
`ifndef CSA_DEFINES_SVH
`define CSA_DEFINES_SVH

// number of cipher units working side by side in the engine (1 to 8).
`define CSA_CALC_INST_NUM 4

// feistel rounds per block, one round per clock.
`define CSA_ROUNDS 4

// output FIFO depth in blocks, also the engine's starting credit count.
`define CSA_OUT_DEPTH 8

// register word addresses.
`define CSA_REG_CTRL   2'd0
`define CSA_REG_KEY_LO 2'd1
`define CSA_REG_KEY_HI 2'd2
`define CSA_REG_COUNT  2'd3

`endif

// File: hw/csa_engine.sv
`default_nettype none
`timescale 1ns/1ps
`include "csa_defines.svh"

module csa_engine
(
	input wire aclk,
	input wire reset,
	input wire csa_pkg::blk_beat_t in_beat,
	input wire in_valid,
	output logic in_ready,
	input wire csa_pkg::key_t key,
	input wire enable,
	output csa_pkg::blk_beat_t out_beat,
	output logic out_push,
	input wire out_credit
);

	localparam int N = `CSA_CALC_INST_NUM;
	localparam int SW = (N > 1) ? $clog2(N) : 1;
	localparam int CW = $clog2(`CSA_OUT_DEPTH + 1);

	logic [SW-1:0] disp_ptr;
	logic [SW-1:0] col_ptr;
	logic [CW-1:0] credit_cnt;
	logic [N-1:0] busy;
	logic [N-1:0] start;
	logic [N-1:0] done;
	csa_pkg::blk_beat_t done_beat [N];
	logic dispatch;

	function automatic logic [SW-1:0] next_unit(input logic [SW-1:0] p);
		if (p == SW'(N - 1))
			next_unit = '0;
		else
			next_unit = p + 1'b1;
	endfunction

	// a credit reserves one FIFO slot for the block being dispatched.
	assign in_ready = !busy[disp_ptr] && (credit_cnt != '0);
	assign dispatch = in_valid && in_ready;

	for (genvar i = 0; i < N; i++)
	begin : g_unit
		assign start[i] = dispatch && (disp_ptr == SW'(i));

		csa_calc u_calc
		(
			.aclk(aclk),
			.reset(reset),
			.start(start[i]),
			.start_beat(in_beat),
			.start_key(key),
			.start_enable(enable),
			.done(done[i]),
			.done_beat(done_beat[i])
		);
	end

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			disp_ptr <= '0;
			col_ptr <= '0;
			busy <= '0;
			out_push <= 1'b0;
			credit_cnt <= CW'(`CSA_OUT_DEPTH);
		end
		else
		begin
			busy <= (busy | start) & ~done;
			if (dispatch)
				disp_ptr <= next_unit(disp_ptr);

			// units finish in dispatch order, so one pointer keeps the order.
			out_push <= done[col_ptr];
			if (done[col_ptr])
				col_ptr <= next_unit(col_ptr);

			case ({dispatch, out_credit})
				2'b10: credit_cnt <= credit_cnt - 1'b1;
				2'b01: credit_cnt <= credit_cnt + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge aclk)
	begin
		if (done[col_ptr])
			out_beat <= done_beat[col_ptr];
	end

endmodule

`default_nettype wire

// File: hw/csa_in_packer.sv
`default_nettype none
`timescale 1ns/1ps

module csa_in_packer
(
	input wire aclk,
	input wire reset,
	input wire s_tvalid,
	output logic s_tready,
	input wire csa_pkg::word_t s_tdata,
	input wire s_tlast,
	output csa_pkg::blk_beat_t in_beat,
	output logic in_valid,
	input wire in_ready
);

	csa_pkg::pack_state_t state;
	csa_pkg::word_t low_word;
	logic rdy_q; // holds s_tready low for the first cycle out of reset.
	logic take;

	// the stream stalls while a packed beat waits for the engine.
	assign s_tready = rdy_q && !in_valid;
	assign take = s_tvalid && s_tready;

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			state <= csa_pkg::PACK_LOW;
			in_valid <= 1'b0;
			rdy_q <= 1'b0;
		end
		else
		begin
			rdy_q <= 1'b1;
			if (in_valid && in_ready)
				in_valid <= 1'b0;
			if (take)
			begin
				if (state == csa_pkg::PACK_LOW)
					state <= csa_pkg::PACK_HIGH;
				else
				begin
					state <= csa_pkg::PACK_LOW;
					in_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (take)
		begin
			if (state == csa_pkg::PACK_LOW)
				low_word <= s_tdata;
			else
				in_beat <= '{data: {s_tdata, low_word}, last: s_tlast}; // tlast of the low word is dropped.
		end
	end

endmodule

`default_nettype wire

// File: hw/csa_out_fifo.sv
`default_nettype none
`timescale 1ns/1ps
`include "csa_defines.svh"

module csa_out_fifo
(
	input wire aclk,
	input wire reset,
	input wire csa_pkg::blk_beat_t out_beat,
	input wire out_push,
	output logic out_credit,
	output logic block_done,
	output logic m_tvalid,
	input wire m_tready,
	output csa_pkg::word_t m_tdata,
	output logic m_tlast
);

	localparam int DEPTH = `CSA_OUT_DEPTH;
	localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	csa_pkg::blk_beat_t mem [DEPTH];
	csa_pkg::blk_beat_t cur; // block being unpacked onto the stream.
	csa_pkg::pack_state_t half;
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic cur_valid;
	logic take;
	logic high_taken;
	logic load;

	function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] p);
		if (p == PW'(DEPTH - 1))
			next_ptr = '0;
		else
			next_ptr = p + 1'b1;
	endfunction

	assign m_tvalid = cur_valid;
	assign m_tdata = (half == csa_pkg::PACK_LOW) ? cur.data[31:0] : cur.data[63:32];
	assign m_tlast = (half == csa_pkg::PACK_HIGH) && cur.last;
	assign take = m_tvalid && m_tready;
	assign high_taken = take && (half == csa_pkg::PACK_HIGH);
	assign load = (count != '0) && (!cur_valid || high_taken);

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			cur_valid <= 1'b0;
			half <= csa_pkg::PACK_LOW;
			out_credit <= 1'b0;
			block_done <= 1'b0;
		end
		else
		begin
			out_credit <= high_taken; // the credit goes back once the whole block has left.
			block_done <= high_taken;
			if (out_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (load)
				rd_ptr <= next_ptr(rd_ptr);
			case ({out_push, load})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase

			if (load)
			begin
				cur_valid <= 1'b1;
				half <= csa_pkg::PACK_LOW;
			end
			else if (high_taken)
				cur_valid <= 1'b0;
			else if (take)
				half <= csa_pkg::PACK_HIGH;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (out_push)
			mem[wr_ptr] <= out_beat;
		if (load)
			cur <= mem[rd_ptr];
	end

endmodule

`default_nettype wire

// File: hw/csa_pkg.sv
`default_nettype none

package csa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [63:0] block_t; // low word is the first word on the stream.
	typedef logic [63:0] key_t;
	typedef logic [1:0] reg_addr_t;
	typedef logic [31:0] count_t;

	// one cipher block plus its packet framing bit.
	typedef struct packed
	{
		block_t data;
		logic last;
	} blk_beat_t;

	typedef enum logic
	{
		CALC_IDLE,
		CALC_RUN
	} calc_state_t;

	// which half of a block is on the 32-bit stream.
	typedef enum logic
	{
		PACK_LOW,
		PACK_HIGH
	} pack_state_t;

endpackage

`default_nettype wire

// File: hw/csa_regs.sv
`default_nettype none
`timescale 1ns/1ps
`include "csa_defines.svh"

module csa_regs
(
	input wire aclk,
	input wire reset,
	input wire reg_wen,
	input wire reg_ren,
	input wire csa_pkg::reg_addr_t reg_addr,
	input wire csa_pkg::word_t reg_wdata,
	output csa_pkg::word_t reg_rdata,
	input wire block_done,
	output csa_pkg::key_t key,
	output logic enable
);

	csa_pkg::word_t key_lo;
	csa_pkg::word_t key_hi;
	csa_pkg::count_t count_q;

	assign key = {key_hi, key_lo};

	always_ff @(posedge aclk)
	begin
		if (reset)
		begin
			enable <= 1'b0;
			key_lo <= '0;
			key_hi <= '0;
			count_q <= '0;
		end
		else
		begin
			if (reg_wen)
			begin
				case (reg_addr)
					`CSA_REG_CTRL: enable <= reg_wdata[0];
					`CSA_REG_KEY_LO: key_lo <= reg_wdata;
					`CSA_REG_KEY_HI: key_hi <= reg_wdata;
					default: ; // count is read only.
				endcase
			end
			if (block_done)
				count_q <= count_q + 32'd1;
		end
	end

	// read data shows up the cycle after reg_ren.
	always_ff @(posedge aclk)
	begin
		if (reg_ren)
		begin
			case (reg_addr)
				`CSA_REG_CTRL: reg_rdata <= {31'd0, enable};
				`CSA_REG_KEY_LO: reg_rdata <= key_lo;
				`CSA_REG_KEY_HI: reg_rdata <= key_hi;
				default: reg_rdata <= count_q;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: sim/csa_accel_sva.sv
`default_nettype none
`timescale 1ns/1ps
`include "csa_defines.svh"

module csa_accel_sva
(
	input wire aclk,
	input wire reset,
	input wire dispatch,
	input wire out_credit,
	input wire out_push,
	input wire [$clog2(`CSA_OUT_DEPTH + 1)-1:0] fifo_count,
	input wire m_tvalid,
	input wire m_tready,
	input wire csa_pkg::word_t m_tdata
);

	localparam int CW = $clog2(`CSA_OUT_DEPTH + 1);

	logic [CW-1:0] in_flight; // blocks dispatched whose credit has not come back yet.
	int fail_count = 0;

	always_ff @(posedge aclk)
	begin
		if (reset)
			in_flight <= '0;
		else
			in_flight <= in_flight + CW'(dispatch) - CW'(out_credit);
	end

	// every dispatched block needs a FIFO slot that no other block holds.
	no_dispatch_without_credit: assert property (@(posedge aclk) disable iff (reset)
		dispatch |-> in_flight < CW'(`CSA_OUT_DEPTH))
		else
		begin
			$error("engine dispatched a block with no credit left");
			fail_count++;
		end

	no_push_when_full: assert property (@(posedge aclk) disable iff (reset)
		out_push |-> fifo_count != CW'(`CSA_OUT_DEPTH))
		else
		begin
			$error("engine pushed a block into a full output FIFO");
			fail_count++;
		end

	// a stalled output word stays put until it is taken.
	stable_out_data: assert property (@(posedge aclk) disable iff (reset)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
		else
		begin
			$error("output word changed or dropped while stalled");
			fail_count++;
		end

endmodule

bind csa_accel csa_accel_sva u_sva
(
	.aclk(aclk),
	.reset(reset),
	.dispatch(u_engine.dispatch),
	.out_credit(out_credit),
	.out_push(u_engine.out_push),
	.fifo_count(u_out_fifo.count),
	.m_tvalid(m_tvalid),
	.m_tready(m_tready),
	.m_tdata(m_tdata)
);

`default_nettype wire

// File: sim/csa_accel_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "csa_defines.svh"

module csa_accel_tb;

	localparam int NUM_TESTS = 4;

	typedef struct packed
	{
		csa_pkg::key_t key;
		logic enable;
		logic [15:0] blocks;
		logic [7:0] pkt_len;
		logic stall; // random m_tready stalls when set.
	} test_row_t;

	test_row_t rows [NUM_TESTS] = '{
		'{64'h0123_4567_89ab_cdef, 1'b0, 16'd6, 8'd3, 1'b0},
		'{64'hdead_beef_0bad_f00d, 1'b1, 16'd9, 8'd1, 1'b0},
		'{64'h5a5a_1234_c3c3_9876, 1'b1, 16'd12, 8'd3, 1'b0},
		'{64'h0f1e_2d3c_4b5a_6978, 1'b1, 16'd40, 8'd5, 1'b1}
	};
	string row_names [NUM_TESTS] = '{"bypass", "scramble_key_a", "scramble_key_b", "stall_order"};

	logic aclk;
	logic reset;
	logic reg_wen;
	logic reg_ren;
	csa_pkg::reg_addr_t reg_addr;
	csa_pkg::word_t reg_wdata;
	csa_pkg::word_t reg_rdata;
	logic s_tvalid;
	logic s_tready;
	csa_pkg::word_t s_tdata;
	logic s_tlast;
	logic m_tvalid;
	logic m_tready;
	csa_pkg::word_t m_tdata;
	logic m_tlast;

	integer seed = 32'h5f3d_c416;
	string cur_name;
	int checks = 0;
	int test_errors = 0;
	int total_errors = 0;
	int failing = 0;
	int sent_total = 0;
	csa_pkg::block_t stim [$];
	csa_pkg::word_t got_data [$];
	logic got_last [$];

	csa_accel u_dut
	(
		.aclk(aclk),
		.reset(reset),
		.reg_wen(reg_wen),
		.reg_ren(reg_ren),
		.reg_addr(reg_addr),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata),
		.s_tvalid(s_tvalid),
		.s_tready(s_tready),
		.s_tdata(s_tdata),
		.s_tlast(s_tlast),
		.m_tvalid(m_tvalid),
		.m_tready(m_tready),
		.m_tdata(m_tdata),
		.m_tlast(m_tlast)
	);

	initial
	begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	// four Feistel rounds over L as the low word and R as the high word.
	function automatic csa_pkg::block_t scramble_model(input csa_pkg::block_t blk,
		input csa_pkg::key_t k);
		csa_pkg::word_t l;
		csa_pkg::word_t r;
		csa_pkg::word_t rk;
		csa_pkg::word_t x;
		l = blk[31:0];
		r = blk[63:32];
		for (int i = 0; i < `CSA_ROUNDS; i++)
		begin
			rk = (i % 2 == 1) ? k[63:32] : k[31:0];
			x = r ^ rk;
			x = ((x << 5) | (x >> 27)) + rk;
			x = l ^ x;
			l = r;
			r = x;
		end
		return {r, l};
	endfunction

	function automatic int total_blocks();
		int sum;
		sum = 0;
		for (int t = 0; t < NUM_TESTS; t++)
			sum += rows[t].blocks;
		return sum;
	endfunction

	task automatic compare_value(input string what, input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp === act)
		else
		begin
			$display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic write_reg(input csa_pkg::reg_addr_t a, input csa_pkg::word_t d);
		reg_wen = 1'b1;
		reg_addr = a;
		reg_wdata = d;
		@(negedge aclk);
		reg_wen = 1'b0;
	endtask

	task automatic read_reg(input csa_pkg::reg_addr_t a, output csa_pkg::word_t d);
		reg_ren = 1'b1;
		reg_addr = a;
		@(negedge aclk);
		reg_ren = 1'b0;
		d = reg_rdata; // registered at the edge in between.
	endtask

	task automatic send_word(input csa_pkg::word_t w, input logic last);
		s_tvalid = 1'b1;
		s_tdata = w;
		s_tlast = last;
		while (!s_tready)
			@(negedge aclk);
		@(negedge aclk);
	endtask

	task automatic send_blocks(input int n, input int pkt);
		for (int b = 0; b < n; b++)
		begin
			send_word(stim[b][31:0], 1'b0);
			send_word(stim[b][63:32], ((b + 1) % pkt) == 0);
		end
		s_tvalid = 1'b0;
		s_tlast = 1'b0;
	endtask

	task automatic collect_words(input int n, input logic stall);
		int r;
		while (got_data.size() < n)
		begin
			@(negedge aclk);
			r = $random(seed);
			m_tready = stall ? r[0] : 1'b1;
			if (m_tvalid && m_tready)
			begin
				got_data.push_back(m_tdata);
				got_last.push_back(m_tlast);
			end
		end
		@(negedge aclk); // the last word is taken at the edge before this one.
		m_tready = 1'b0;
	endtask

	task automatic run_test(input int t);
		csa_pkg::word_t rd;
		csa_pkg::block_t blk;
		csa_pkg::word_t exp_data [$];
		logic exp_last [$];
		int n;
		int pkt;
		n = rows[t].blocks;
		pkt = rows[t].pkt_len;
		cur_name = row_names[t];
		test_errors = 0;
		write_reg(`CSA_REG_KEY_LO, rows[t].key[31:0]);
		write_reg(`CSA_REG_KEY_HI, rows[t].key[63:32]);
		write_reg(`CSA_REG_CTRL, {31'd0, rows[t].enable});
		read_reg(`CSA_REG_KEY_LO, rd);
		compare_value("key low readback", rows[t].key[31:0], rd);
		read_reg(`CSA_REG_KEY_HI, rd);
		compare_value("key high readback", rows[t].key[63:32], rd);
		read_reg(`CSA_REG_CTRL, rd);
		compare_value("control readback", {31'd0, rows[t].enable}, rd);

		stim.delete();
		got_data.delete();
		got_last.delete();
		for (int b = 0; b < n; b++)
		begin
			blk[31:0] = $random(seed);
			blk[63:32] = $random(seed);
			stim.push_back(blk);
			blk = rows[t].enable ? scramble_model(blk, rows[t].key) : blk;
			exp_data.push_back(blk[31:0]);
			exp_last.push_back(1'b0);
			exp_data.push_back(blk[63:32]);
			exp_last.push_back(((b + 1) % pkt) == 0);
		end

		fork
			send_blocks(n, pkt);
			collect_words(2 * n, rows[t].stall);
		join

		for (int i = 0; i < 2 * n; i++)
		begin
			compare_value($sformatf("word %0d data", i), exp_data[i], got_data[i]);
			compare_value($sformatf("word %0d tlast", i), exp_last[i], got_last[i]);
		end

		repeat (3) @(negedge aclk); // let block_done reach the counter.
		checks++;
		assert (!m_tvalid)
		else
		begin
			$display("%s: an extra output word showed up after %0d words", cur_name, 2 * n);
			test_errors++;
		end
		sent_total += n;
		read_reg(`CSA_REG_COUNT, rd);
		compare_value("block count", sent_total, rd);

		if (test_errors == 0)
			$display("%s: %0d blocks ok", cur_name, n);
		else
			$display("%s: %0d errors", cur_name, test_errors);
		total_errors += test_errors;
		if (test_errors != 0)
			failing++;
	endtask

	initial
	begin
		int limit;
		limit = total_blocks() * 40 + 1000;
		repeat (limit) @(posedge aclk);
		$display("timeout: the run did not finish within %0d cycles", limit);
		$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		reg_wen = 1'b0;
		reg_ren = 1'b0;
		reg_addr = '0;
		reg_wdata = '0;
		s_tvalid = 1'b0;
		s_tdata = '0;
		s_tlast = 1'b0;
		m_tready = 1'b0;
		repeat (4) @(negedge aclk);
		reset = 1'b0;
		checks++;
		assert (!s_tready && !m_tvalid)
		else
		begin
			$display("s_tready or m_tvalid was high in the first cycle after reset");
			total_errors++;
		end
		@(negedge aclk);
		for (int t = 0; t < NUM_TESTS; t++)
			run_test(t);
		$display("%0d tests, %0d failing, %0d checks, %0d errors, %0d assertion failures",
			NUM_TESTS, failing, checks, total_errors, u_dut.u_sva.fail_count);
		if (total_errors == 0 && u_dut.u_sva.fail_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire
